// ==== ex_types_pkg.sv ====
// Execute stage types
// Word and lane widths, selector and operation encodings, and the
// records that cross the ID/EX and EX/MEM boundaries

package ex_types_pkg;

  localparam int XLEN       = 32;
  localparam int BYTE_LANES = 4;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [4:0]            reg_addr_t;
  typedef logic [BYTE_LANES-1:0] byte_en_t;

  // Bypass source for a register operand
  typedef enum logic [1:0] {FWD_NONE, FWD_M, FWD_W} fwd_sel_t;

  typedef enum logic {A_RS1, A_IMM} alu_a_sel_t;

  typedef enum logic [1:0] {B_RS1, B_RS2, B_IMM} alu_b_sel_t;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLL, SRL, SRA, SLT, SLTU
  } aluop_t;

  // Branch condition, funct3 order
  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } branch_t;

  // Access size, shared by loads and stores (funct3 codes)
  typedef enum logic [2:0] {
    LB  = 3'b000,
    LH  = 3'b001,
    LW  = 3'b010,
    LBU = 3'b100,
    LHU = 3'b101
  } load_t;

  // Instruction as handed over by decode
  typedef struct packed {
    word_t      pc;
    word_t      pc4;
    word_t      rs1_data;
    word_t      rs2_data;
    word_t      imm_a;
    word_t      imm_b;
    word_t      j_offset;
    word_t      br_imm;
    aluop_t     aluop;
    alu_a_sel_t alu_a_sel;
    alu_b_sel_t alu_b_sel;
    branch_t    branch_type;
    load_t      load_type;
    reg_addr_t  reg_rd;
    reg_addr_t  reg_rs1;
    reg_addr_t  reg_rs2;
    logic       wen;
    logic       w_sel;
    logic       dwen;
    logic       dren;
    logic       j_sel;
    logic       jump_instr;
    logic       branch_instr;
    logic       prediction;
    logic       halt_instr;
  } id_ex_t;

  // Bypass selection and the later-stage results it picks from
  typedef struct packed {
    fwd_sel_t bypass_rs1;
    fwd_sel_t bypass_rs2;
    word_t    rd_data_mem;
    word_t    rd_data_wb;
  } fwd_t;

  typedef struct packed {
    word_t     alu_out;
    word_t     store_wdata;
    word_t     jump_addr;
    word_t     br_resolved_addr;
    word_t     pc;
    word_t     pc4;
    byte_en_t  byte_en;
    load_t     load_type;
    reg_addr_t reg_rd;
    logic      wen;
    logic      w_sel;
    logic      dwen;
    logic      dren;
    logic      jump_instr;
    logic      branch_instr;
    logic      branch_taken;
    logic      prediction;
    logic      halt_instr;
    logic      intr_seen;
    logic      token;
  } ex_mem_t;

  // Empty EX/MEM slot
  localparam ex_mem_t ex_mem_reset_c = '0;

endpackage

// ==== ex_operand_select.sv ====
// Operand selection
// Resolves the bypass for rs1 and rs2, then steers the ALU ports

`timescale 1ns/100ps

module ex_operand_select (
  input  ex_types_pkg::id_ex_t id_ex,
  input  ex_types_pkg::fwd_t   fwd,
  output ex_types_pkg::word_t  rs1_fwd,
  output ex_types_pkg::word_t  rs2_fwd,
  output ex_types_pkg::word_t  alu_a,
  output ex_types_pkg::word_t  alu_b
);

  function automatic ex_types_pkg::word_t bypass(
    input ex_types_pkg::fwd_sel_t sel,
    input ex_types_pkg::word_t    reg_val,
    input ex_types_pkg::word_t    mem_val,
    input ex_types_pkg::word_t    wb_val
  );
    case (sel)
      ex_types_pkg::FWD_M: return mem_val;
      ex_types_pkg::FWD_W: return wb_val;
      default:             return reg_val;
    endcase
  endfunction

  assign rs1_fwd = bypass(fwd.bypass_rs1, id_ex.rs1_data, fwd.rd_data_mem, fwd.rd_data_wb);
  assign rs2_fwd = bypass(fwd.bypass_rs2, id_ex.rs2_data, fwd.rd_data_mem, fwd.rd_data_wb);

  // Port A is rs1 or the upper/pc immediate from decode
  assign alu_a = (id_ex.alu_a_sel == ex_types_pkg::A_RS1) ? rs1_fwd : id_ex.imm_a;

  always_comb begin
    case (id_ex.alu_b_sel)
      ex_types_pkg::B_RS1: alu_b = rs1_fwd;
      ex_types_pkg::B_RS2: alu_b = rs2_fwd;
      ex_types_pkg::B_IMM: alu_b = id_ex.imm_b;
      default:             alu_b = '0;
    endcase
  end

endmodule

// ==== ex_alu.sv ====
// Integer ALU
// The ten RV32I register/immediate operations, purely combinational

`timescale 1ns/100ps

module ex_alu (
  input  ex_types_pkg::word_t  a,
  input  ex_types_pkg::word_t  b,
  input  ex_types_pkg::aluop_t aluop,
  output ex_types_pkg::word_t  result
);

  logic [4:0] shamt;

  // Only the low five bits shift on RV32
  assign shamt = b[4:0];

  always_comb begin
    case (aluop)
      ex_types_pkg::ADD:  result = a + b;
      ex_types_pkg::SUB:  result = a - b;
      ex_types_pkg::AND:  result = a & b;
      ex_types_pkg::OR:   result = a | b;
      ex_types_pkg::XOR:  result = a ^ b;
      ex_types_pkg::SLL:  result = a << shamt;
      ex_types_pkg::SRL:  result = a >> shamt;
      ex_types_pkg::SRA:  result = ex_types_pkg::word_t'($signed(a) >>> shamt);
      ex_types_pkg::SLT:  result = ex_types_pkg::word_t'($signed(a) < $signed(b));
      ex_types_pkg::SLTU: result = ex_types_pkg::word_t'(a < b);
      default:            result = '0;
    endcase
  end

  // Decode must never hand over an unused operation code
  always_comb begin
    if (!$isunknown(aluop)) begin
      assert (aluop inside {ex_types_pkg::ADD, ex_types_pkg::SUB, ex_types_pkg::AND,
                            ex_types_pkg::OR, ex_types_pkg::XOR, ex_types_pkg::SLL,
                            ex_types_pkg::SRL, ex_types_pkg::SRA, ex_types_pkg::SLT,
                            ex_types_pkg::SLTU})
        else $error("ex_alu: undefined aluop %0d", aluop);
    end
  end

endmodule

// ==== ex_branch_resolve.sv ====
// Branch and jump resolution
// Evaluates the branch condition on bypassed operands, picks the
// next address, and forms the JAL/JALR target

`timescale 1ns/100ps

module ex_branch_resolve (
  input  ex_types_pkg::id_ex_t id_ex,
  input  ex_types_pkg::word_t  rs1_fwd,
  input  ex_types_pkg::word_t  rs2_fwd,
  output logic                 branch_taken,
  output ex_types_pkg::word_t  br_resolved_addr,
  output ex_types_pkg::word_t  jump_addr
);

  logic                cond;
  ex_types_pkg::word_t br_target;
  ex_types_pkg::word_t jump_base;
  ex_types_pkg::word_t jump_sum;

  always_comb begin
    case (id_ex.branch_type)
      ex_types_pkg::BEQ:  cond = (rs1_fwd == rs2_fwd);
      ex_types_pkg::BNE:  cond = (rs1_fwd != rs2_fwd);
      ex_types_pkg::BLT:  cond = ($signed(rs1_fwd) < $signed(rs2_fwd));
      ex_types_pkg::BGE:  cond = ($signed(rs1_fwd) >= $signed(rs2_fwd));
      ex_types_pkg::BLTU: cond = (rs1_fwd < rs2_fwd);
      ex_types_pkg::BGEU: cond = (rs1_fwd >= rs2_fwd);
      default:            cond = 1'b0;
    endcase
  end

  // Non-branch instructions never redirect
  assign branch_taken = id_ex.branch_instr & cond;

  assign br_target        = id_ex.pc + id_ex.br_imm;
  assign br_resolved_addr = branch_taken ? br_target : id_ex.pc4;

  // JAL is pc relative, JALR is register relative
  assign jump_base = id_ex.j_sel ? id_ex.pc : rs1_fwd;
  assign jump_sum  = jump_base + id_ex.j_offset;

  // JALR drops bit 0 of the sum
  always_comb begin
    if (id_ex.j_sel) begin
      jump_addr = jump_sum;
    end else begin
      jump_addr = {jump_sum[ex_types_pkg::XLEN-1:1], 1'b0};
    end
  end

endmodule

// ==== ex_mem_request.sv ====
// Data memory request
// Byte lane mask from access size and address offset, plus store data

`timescale 1ns/100ps

module ex_mem_request (
  input  ex_types_pkg::word_t    addr,
  input  ex_types_pkg::load_t    load_type,
  input  ex_types_pkg::word_t    rs2_fwd,
  output ex_types_pkg::byte_en_t byte_en,
  output ex_types_pkg::word_t    store_wdata
);

  logic [1:0] offset;

  assign offset = addr[1:0];

  always_comb begin
    case (load_type)
      ex_types_pkg::LB, ex_types_pkg::LBU: begin
        byte_en = ex_types_pkg::byte_en_t'(1) << offset;
      end
      ex_types_pkg::LH, ex_types_pkg::LHU: begin
        case (offset)
          2'b00:   byte_en = 4'b0011;
          2'b10:   byte_en = 4'b1100;
          // Misaligned halfword gets no lanes
          default: byte_en = 4'b0000;
        endcase
      end
      ex_types_pkg::LW: byte_en = 4'b1111;
      default:          byte_en = 4'b0000;
    endcase
  end

  // Lane alignment of store data happens in the memory stage
  assign store_wdata = rs2_fwd;

endmodule

// ==== ex_pipe_ctrl.sv ====
// EX/MEM control
// Prioritizes halt/flush, memory-request clear and load into three
// exclusive strobes, and latches pending interrupts

`timescale 1ns/100ps

module ex_pipe_ctrl (
  input  logic CLK,
  input  logic nRST,
  input  logic pc_en,
  input  logic ex_mem_flush,
  input  logic halt,
  input  logic dmem_access,
  input  logic dmem_busy,
  input  logic intr,
  input  logic intr_taken,
  output logic clear_all,
  output logic clear_mem,
  output logic load,
  output logic intr_seen
);

  // Flush only counts when the pipe advances
  assign clear_all = halt | (ex_mem_flush & pc_en);

  // Data access finishing frees the bus for instruction fetch
  assign clear_mem = ~clear_all & dmem_access & ~dmem_busy;

  assign load = ~clear_all & ~clear_mem & pc_en;

  // Interrupt is polled every cycle so a busy pipe still catches it
  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      intr_seen <= 1'b0;
    end else if (halt) begin
      intr_seen <= 1'b0;
    end else if (intr) begin
      intr_seen <= 1'b1;
    end else if (intr_taken) begin
      intr_seen <= 1'b0;
    end
  end

  // The register sees at most one action per edge
  assert property (@(posedge CLK) disable iff (!nRST)
    $onehot0({clear_all, clear_mem, load}))
    else $error("ex_pipe_ctrl: overlapping EX/MEM strobes");

endmodule

// ==== ex_mem_reg.sv ====
// EX/MEM pipeline register
// Builds the outgoing record from decode fields and execute results,
// then clears, partially clears, loads or holds it

`timescale 1ns/100ps

module ex_mem_reg (
  input  logic                   CLK,
  input  logic                   nRST,
  input  logic                   clear_all,
  input  logic                   clear_mem,
  input  logic                   load,
  input  ex_types_pkg::id_ex_t   id_ex,
  input  ex_types_pkg::word_t    alu_out,
  input  ex_types_pkg::word_t    store_wdata,
  input  ex_types_pkg::word_t    jump_addr,
  input  ex_types_pkg::word_t    br_resolved_addr,
  input  ex_types_pkg::byte_en_t byte_en,
  input  logic                   branch_taken,
  input  logic                   intr_seen,
  output ex_types_pkg::ex_mem_t  ex_mem
);

  ex_types_pkg::ex_mem_t ex_mem_next;

  always_comb begin
    ex_mem_next                  = ex_types_pkg::ex_mem_reset_c;
    ex_mem_next.alu_out          = alu_out;
    ex_mem_next.store_wdata      = store_wdata;
    ex_mem_next.jump_addr        = jump_addr;
    ex_mem_next.br_resolved_addr = br_resolved_addr;
    ex_mem_next.pc               = id_ex.pc;
    ex_mem_next.pc4              = id_ex.pc4;
    ex_mem_next.byte_en          = byte_en;
    ex_mem_next.load_type        = id_ex.load_type;
    ex_mem_next.reg_rd           = id_ex.reg_rd;
    ex_mem_next.wen              = id_ex.wen;
    ex_mem_next.w_sel            = id_ex.w_sel;
    ex_mem_next.dwen             = id_ex.dwen;
    ex_mem_next.dren             = id_ex.dren;
    ex_mem_next.jump_instr       = id_ex.jump_instr;
    ex_mem_next.branch_instr     = id_ex.branch_instr;
    ex_mem_next.branch_taken     = branch_taken;
    ex_mem_next.prediction       = id_ex.prediction;
    ex_mem_next.halt_instr       = id_ex.halt_instr;
    ex_mem_next.intr_seen        = intr_seen;
    // Marks a real instruction in the slot
    ex_mem_next.token            = 1'b1;
  end

  always_ff @(posedge CLK, negedge nRST) begin
    if (!nRST) begin
      ex_mem <= ex_types_pkg::ex_mem_reset_c;
    end else if (clear_all) begin
      ex_mem <= ex_types_pkg::ex_mem_reset_c;
    end else if (clear_mem) begin
      // Request done, drop it so it is not issued twice
      ex_mem.dwen <= 1'b0;
      ex_mem.dren <= 1'b0;
    end else if (load) begin
      ex_mem <= ex_mem_next;
    end
  end

  // A cleared slot must not write the register file or memory
  assert property (@(posedge CLK) disable iff (!nRST)
    clear_all |=> !(ex_mem.wen || ex_mem.dwen || ex_mem.dren))
    else $error("ex_mem_reg: side effects survive a full clear");

endmodule

// ==== execute_stage.sv ====
// RV32I execute stage
// Bypass, ALU, branch/jump resolution and memory request feeding the
// EX/MEM register

`timescale 1ns/100ps

module execute_stage (
  input  logic                  CLK,
  input  logic                  nRST,
  input  ex_types_pkg::id_ex_t  id_ex,
  input  ex_types_pkg::fwd_t    fwd,
  input  logic                  pc_en,
  input  logic                  ex_mem_flush,
  input  logic                  halt,
  input  logic                  dmem_access,
  input  logic                  dmem_busy,
  input  logic                  intr,
  input  logic                  intr_taken,
  output ex_types_pkg::ex_mem_t ex_mem
);

  ex_types_pkg::word_t    rs1_fwd;
  ex_types_pkg::word_t    rs2_fwd;
  ex_types_pkg::word_t    alu_a;
  ex_types_pkg::word_t    alu_b;
  ex_types_pkg::word_t    alu_out;
  ex_types_pkg::word_t    br_resolved_addr;
  ex_types_pkg::word_t    jump_addr;
  ex_types_pkg::word_t    store_wdata;
  ex_types_pkg::byte_en_t byte_en;
  logic                   branch_taken;
  logic                   clear_all;
  logic                   clear_mem;
  logic                   load;
  logic                   intr_seen;

  ex_operand_select u_operand_select (
    .id_ex   (id_ex),
    .fwd     (fwd),
    .rs1_fwd (rs1_fwd),
    .rs2_fwd (rs2_fwd),
    .alu_a   (alu_a),
    .alu_b   (alu_b)
  );

  ex_alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .aluop  (id_ex.aluop),
    .result (alu_out)
  );

  ex_branch_resolve u_branch_resolve (
    .id_ex            (id_ex),
    .rs1_fwd          (rs1_fwd),
    .rs2_fwd          (rs2_fwd),
    .branch_taken     (branch_taken),
    .br_resolved_addr (br_resolved_addr),
    .jump_addr        (jump_addr)
  );

  // ALU output doubles as the data address
  ex_mem_request u_mem_request (
    .addr        (alu_out),
    .load_type   (id_ex.load_type),
    .rs2_fwd     (rs2_fwd),
    .byte_en     (byte_en),
    .store_wdata (store_wdata)
  );

  ex_pipe_ctrl u_pipe_ctrl (
    .CLK          (CLK),
    .nRST         (nRST),
    .pc_en        (pc_en),
    .ex_mem_flush (ex_mem_flush),
    .halt         (halt),
    .dmem_access  (dmem_access),
    .dmem_busy    (dmem_busy),
    .intr         (intr),
    .intr_taken   (intr_taken),
    .clear_all    (clear_all),
    .clear_mem    (clear_mem),
    .load         (load),
    .intr_seen    (intr_seen)
  );

  ex_mem_reg u_ex_mem_reg (
    .CLK              (CLK),
    .nRST             (nRST),
    .clear_all        (clear_all),
    .clear_mem        (clear_mem),
    .load             (load),
    .id_ex            (id_ex),
    .alu_out          (alu_out),
    .store_wdata      (store_wdata),
    .jump_addr        (jump_addr),
    .br_resolved_addr (br_resolved_addr),
    .byte_en          (byte_en),
    .branch_taken     (branch_taken),
    .intr_seen        (intr_seen),
    .ex_mem           (ex_mem)
  );

endmodule

// ==== tb_execute_stage.sv ====
// Execute stage testbench
// Directed tests against a reference model of the ALU, branch, jump and
// byte lane rules, checked on the registered EX/MEM record

`timescale 1ns/100ps

module tb_execute_stage;

  localparam int unsigned SEED = 32'h58e1ff55;
  // Tests take under 200 cycles
  localparam int MAX_CYCLES = 400;

  logic                  CLK;
  logic                  nRST;
  ex_types_pkg::id_ex_t  id_ex;
  ex_types_pkg::fwd_t    fwd;
  logic                  pc_en;
  logic                  ex_mem_flush;
  logic                  halt;
  logic                  dmem_access;
  logic                  dmem_busy;
  logic                  intr;
  logic                  intr_taken;
  ex_types_pkg::ex_mem_t ex_mem;

  int                    errors;
  int                    checks;
  int                    cycles;
  int                    seed_init;
  logic                  seen_exp;
  ex_types_pkg::ex_mem_t last;

  execute_stage u_dut (
    .CLK          (CLK),
    .nRST         (nRST),
    .id_ex        (id_ex),
    .fwd          (fwd),
    .pc_en        (pc_en),
    .ex_mem_flush (ex_mem_flush),
    .halt         (halt),
    .dmem_access  (dmem_access),
    .dmem_busy    (dmem_busy),
    .intr         (intr),
    .intr_taken   (intr_taken),
    .ex_mem       (ex_mem)
  );

  always #50 CLK = ~CLK;

  always @(posedge CLK) begin
    cycles = cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("SIMULATION FAILED");
      $finish;
    end
  end

  // Reference model

  function automatic logic signed_less(input ex_types_pkg::word_t a,
                                       input ex_types_pkg::word_t b);
    // Differing signs decide on the sign of a alone
    if (a[31] != b[31]) begin
      return a[31];
    end
    return a < b;
  endfunction

  function automatic ex_types_pkg::word_t alu_model(input ex_types_pkg::aluop_t op,
                                                    input ex_types_pkg::word_t a,
                                                    input ex_types_pkg::word_t b);
    logic [4:0]          sh;
    ex_types_pkg::word_t fill;
    sh   = b[4:0];
    fill = a[31] ? ~(32'hffff_ffff >> sh) : 32'h0;
    case (op)
      ex_types_pkg::ADD:  return a + b;
      ex_types_pkg::SUB:  return a + ~b + 32'd1;
      ex_types_pkg::AND:  return a & b;
      ex_types_pkg::OR:   return a | b;
      ex_types_pkg::XOR:  return a ^ b;
      ex_types_pkg::SLL:  return a << sh;
      ex_types_pkg::SRL:  return a >> sh;
      ex_types_pkg::SRA:  return (a >> sh) | fill;
      ex_types_pkg::SLT:  return {31'b0, signed_less(a, b)};
      ex_types_pkg::SLTU: return {31'b0, a < b};
      default:            return 32'h0;
    endcase
  endfunction

  function automatic logic branch_model(input ex_types_pkg::branch_t bt,
                                        input ex_types_pkg::word_t a,
                                        input ex_types_pkg::word_t b);
    case (bt)
      ex_types_pkg::BEQ:  return a == b;
      ex_types_pkg::BNE:  return a != b;
      ex_types_pkg::BLT:  return signed_less(a, b);
      ex_types_pkg::BGE:  return !signed_less(a, b);
      ex_types_pkg::BLTU: return a < b;
      ex_types_pkg::BGEU: return !(a < b);
      default:            return 1'b0;
    endcase
  endfunction

  function automatic ex_types_pkg::byte_en_t lanes_model(input ex_types_pkg::load_t lt,
                                                         input ex_types_pkg::word_t addr);
    case (lt)
      ex_types_pkg::LW: return 4'b1111;
      ex_types_pkg::LB, ex_types_pkg::LBU: begin
        case (addr[1:0])
          2'd0:    return 4'b0001;
          2'd1:    return 4'b0010;
          2'd2:    return 4'b0100;
          default: return 4'b1000;
        endcase
      end
      ex_types_pkg::LH, ex_types_pkg::LHU: begin
        if (addr[1:0] == 2'd0) begin
          return 4'b0011;
        end
        if (addr[1:0] == 2'd2) begin
          return 4'b1100;
        end
        return 4'b0000;
      end
      default: return 4'b0000;
    endcase
  endfunction

  function automatic ex_types_pkg::word_t jump_model(input logic j_sel,
                                                     input ex_types_pkg::word_t pc,
                                                     input ex_types_pkg::word_t rs1,
                                                     input ex_types_pkg::word_t offset);
    ex_types_pkg::word_t sum;
    sum = j_sel ? pc + offset : rs1 + offset;
    if (!j_sel) begin
      sum[0] = 1'b0;
    end
    return sum;
  endfunction

  function automatic ex_types_pkg::word_t pick_source(input ex_types_pkg::fwd_sel_t sel,
                                                      input ex_types_pkg::word_t reg_val,
                                                      input ex_types_pkg::fwd_t f);
    if (sel == ex_types_pkg::FWD_M) begin
      return f.rd_data_mem;
    end
    if (sel == ex_types_pkg::FWD_W) begin
      return f.rd_data_wb;
    end
    return reg_val;
  endfunction

  // Record expected one edge after a load
  function automatic ex_types_pkg::ex_mem_t expected_load(input ex_types_pkg::id_ex_t d,
                                                          input ex_types_pkg::fwd_t f,
                                                          input logic seen);
    ex_types_pkg::ex_mem_t e;
    ex_types_pkg::word_t   r1;
    ex_types_pkg::word_t   r2;
    ex_types_pkg::word_t   a;
    ex_types_pkg::word_t   b;
    r1 = pick_source(f.bypass_rs1, d.rs1_data, f);
    r2 = pick_source(f.bypass_rs2, d.rs2_data, f);
    a  = (d.alu_a_sel == ex_types_pkg::A_IMM) ? d.imm_a : r1;
    case (d.alu_b_sel)
      ex_types_pkg::B_RS1: b = r1;
      ex_types_pkg::B_RS2: b = r2;
      default:             b = d.imm_b;
    endcase
    e                  = '0;
    e.alu_out          = alu_model(d.aluop, a, b);
    e.store_wdata      = r2;
    e.jump_addr        = jump_model(d.j_sel, d.pc, r1, d.j_offset);
    e.branch_taken     = d.branch_instr && branch_model(d.branch_type, r1, r2);
    e.br_resolved_addr = e.branch_taken ? d.pc + d.br_imm : d.pc4;
    e.pc               = d.pc;
    e.pc4              = d.pc4;
    e.byte_en          = lanes_model(d.load_type, e.alu_out);
    e.load_type        = d.load_type;
    e.reg_rd           = d.reg_rd;
    e.wen              = d.wen;
    e.w_sel            = d.w_sel;
    e.dwen             = d.dwen;
    e.dren             = d.dren;
    e.jump_instr       = d.jump_instr;
    e.branch_instr     = d.branch_instr;
    e.prediction       = d.prediction;
    e.halt_instr       = d.halt_instr;
    e.intr_seen        = seen;
    e.token            = 1'b1;
    return e;
  endfunction

  // Stimulus and checking helpers

  function automatic ex_types_pkg::id_ex_t random_instr();
    ex_types_pkg::id_ex_t d;
    d              = '0;
    d.pc           = $urandom & 32'hffff_fffc;
    d.pc4          = d.pc + 32'd4;
    d.rs1_data     = $urandom;
    d.rs2_data     = $urandom;
    d.imm_a        = $urandom;
    d.imm_b        = $urandom;
    d.j_offset     = $urandom;
    d.br_imm       = $urandom & 32'hffff_fffe;
    d.aluop        = ex_types_pkg::ADD;
    d.alu_a_sel    = ex_types_pkg::A_RS1;
    d.alu_b_sel    = ex_types_pkg::B_RS2;
    d.branch_type  = ex_types_pkg::BEQ;
    d.load_type    = ex_types_pkg::LW;
    d.reg_rd       = 5'($urandom);
    d.reg_rs1      = 5'($urandom);
    d.reg_rs2      = 5'($urandom);
    d.wen          = 1'($urandom);
    d.w_sel        = 1'($urandom);
    d.dwen         = 1'($urandom);
    d.dren         = 1'($urandom);
    d.j_sel        = 1'($urandom);
    d.jump_instr   = 1'($urandom);
    d.prediction   = 1'($urandom);
    d.halt_instr   = 1'($urandom);
    return d;
  endfunction

  function automatic ex_types_pkg::fwd_t random_fwd();
    ex_types_pkg::fwd_t f;
    f.bypass_rs1  = ex_types_pkg::FWD_NONE;
    f.bypass_rs2  = ex_types_pkg::FWD_NONE;
    f.rd_data_mem = $urandom;
    f.rd_data_wb  = $urandom;
    return f;
  endfunction

  task automatic check_field(input string tag, input string name,
                             input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %s: ex_mem.%s = 0x%h, expected 0x%h", tag, name, got, exp);
    end
  endtask

  task automatic check_record(input string tag, input ex_types_pkg::ex_mem_t exp);
    check_field(tag, "alu_out", ex_mem.alu_out, exp.alu_out);
    check_field(tag, "store_wdata", ex_mem.store_wdata, exp.store_wdata);
    check_field(tag, "jump_addr", ex_mem.jump_addr, exp.jump_addr);
    check_field(tag, "br_resolved_addr", ex_mem.br_resolved_addr, exp.br_resolved_addr);
    check_field(tag, "pc", ex_mem.pc, exp.pc);
    check_field(tag, "pc4", ex_mem.pc4, exp.pc4);
    check_field(tag, "byte_en", 32'(ex_mem.byte_en), 32'(exp.byte_en));
    check_field(tag, "load_type", 32'(ex_mem.load_type), 32'(exp.load_type));
    check_field(tag, "reg_rd", 32'(ex_mem.reg_rd), 32'(exp.reg_rd));
    check_field(tag, "wen", 32'(ex_mem.wen), 32'(exp.wen));
    check_field(tag, "w_sel", 32'(ex_mem.w_sel), 32'(exp.w_sel));
    check_field(tag, "dwen", 32'(ex_mem.dwen), 32'(exp.dwen));
    check_field(tag, "dren", 32'(ex_mem.dren), 32'(exp.dren));
    check_field(tag, "jump_instr", 32'(ex_mem.jump_instr), 32'(exp.jump_instr));
    check_field(tag, "branch_instr", 32'(ex_mem.branch_instr), 32'(exp.branch_instr));
    check_field(tag, "branch_taken", 32'(ex_mem.branch_taken), 32'(exp.branch_taken));
    check_field(tag, "prediction", 32'(ex_mem.prediction), 32'(exp.prediction));
    check_field(tag, "halt_instr", 32'(ex_mem.halt_instr), 32'(exp.halt_instr));
    check_field(tag, "intr_seen", 32'(ex_mem.intr_seen), 32'(exp.intr_seen));
    check_field(tag, "token", 32'(ex_mem.token), 32'(exp.token));
  endtask

  // Called at a falling edge with the inputs already driven
  task automatic load_and_check(input string tag);
    last = expected_load(id_ex, fwd, seen_exp);
    @(negedge CLK);
    check_record(tag, last);
  endtask

  task automatic hold_and_check(input string tag);
    @(negedge CLK);
    check_record(tag, last);
  endtask

  task automatic apply_reset();
    nRST = 1'b0;
    repeat (5) @(negedge CLK);
    last     = ex_types_pkg::ex_mem_reset_c;
    seen_exp = 1'b0;
    check_record("reset", last);
    nRST = 1'b1;
  endtask

  // Directed tests

  task automatic alu_forwarding_test();
    int i;
    for (i = 0; i < 30; i++) begin
      id_ex            = random_instr();
      id_ex.aluop      = ex_types_pkg::aluop_t'(i % 10);
      id_ex.alu_a_sel  = ex_types_pkg::alu_a_sel_t'((i + i / 10) % 2);
      id_ex.alu_b_sel  = ex_types_pkg::alu_b_sel_t'(i / 10);
      id_ex.wen        = 1'b1;
      fwd              = random_fwd();
      fwd.bypass_rs1   = ex_types_pkg::fwd_sel_t'(i % 3);
      fwd.bypass_rs2   = ex_types_pkg::fwd_sel_t'((i + 1) % 3);
      pc_en            = 1'b1;
      load_and_check("alu");
    end
  endtask

  task automatic branch_jump_test();
    ex_types_pkg::branch_t types [6] = '{ex_types_pkg::BEQ, ex_types_pkg::BNE,
                                         ex_types_pkg::BLT, ex_types_pkg::BGE,
                                         ex_types_pkg::BLTU, ex_types_pkg::BGEU};
    ex_types_pkg::word_t   lo;
    ex_types_pkg::word_t   hi;
    int                    t;
    int                    s;
    int                    r;
    for (t = 0; t < 6; t++) begin
      for (s = 0; s < 2; s++) begin
        for (r = 0; r < 3; r++) begin
          // Second set puts a negative value above a positive one unsigned
          if (s == 0) begin
            lo = $urandom & 32'h3fff_ffff;
            hi = ($urandom & 32'h7fff_ffff) | 32'h4000_0000;
          end else begin
            lo = $urandom & 32'h7fff_ffff;
            hi = $urandom | 32'h8000_0000;
          end
          id_ex              = random_instr();
          id_ex.branch_instr = 1'b1;
          id_ex.branch_type  = types[t];
          id_ex.rs1_data     = (r == 2) ? hi : lo;
          id_ex.rs2_data     = (r == 1) ? hi : lo;
          id_ex.j_sel        = 1'(r);
          fwd                = random_fwd();
          load_and_check("branch");
        end
      end
    end
    // Equal operands on a non-branch never redirect
    id_ex              = random_instr();
    id_ex.rs2_data     = id_ex.rs1_data;
    id_ex.branch_instr = 1'b0;
    load_and_check("not_branch");
    // Odd sums, bit 0 kept for JAL and cleared for JALR
    id_ex          = random_instr();
    id_ex.j_sel    = 1'b1;
    id_ex.j_offset = $urandom | 32'h1;
    load_and_check("jal");
    id_ex          = random_instr();
    id_ex.j_sel    = 1'b0;
    id_ex.rs1_data = $urandom & 32'hffff_fffe;
    id_ex.j_offset = $urandom | 32'h1;
    load_and_check("jalr");
  endtask

  task automatic mem_request_test();
    ex_types_pkg::load_t sizes [5] = '{ex_types_pkg::LB, ex_types_pkg::LH, ex_types_pkg::LW,
                                      ex_types_pkg::LBU, ex_types_pkg::LHU};
    int                  k;
    int                  off;
    for (k = 0; k < 5; k++) begin
      for (off = 0; off < 4; off++) begin
        id_ex           = random_instr();
        id_ex.load_type = sizes[k];
        id_ex.aluop     = ex_types_pkg::ADD;
        id_ex.alu_a_sel = ex_types_pkg::A_IMM;
        id_ex.alu_b_sel = ex_types_pkg::B_IMM;
        id_ex.imm_a     = $urandom & 32'hffff_fffc;
        id_ex.imm_b     = 32'(off);
        fwd             = random_fwd();
        fwd.bypass_rs2  = ex_types_pkg::fwd_sel_t'((k + off) % 3);
        load_and_check("mem_request");
      end
    end
  endtask

  task automatic clear_hold_test();
    id_ex = random_instr();
    fwd   = random_fwd();
    load_and_check("load_before_flush");
    ex_mem_flush = 1'b1;
    last         = ex_types_pkg::ex_mem_reset_c;
    hold_and_check("flush");
    ex_mem_flush = 1'b0;
    id_ex        = random_instr();
    load_and_check("load_before_stall");
    // Flush without pc_en is a hold
    ex_mem_flush = 1'b1;
    pc_en        = 1'b0;
    id_ex        = random_instr();
    hold_and_check("flush_stalled");
    ex_mem_flush = 1'b0;
    repeat (3) begin
      id_ex = random_instr();
      fwd   = random_fwd();
      hold_and_check("stall");
    end
    pc_en = 1'b1;
    halt  = 1'b1;
    last  = ex_types_pkg::ex_mem_reset_c;
    hold_and_check("halt");
    halt  = 1'b0;
    id_ex = random_instr();
    load_and_check("load_before_reset");
    apply_reset();
  endtask

  task automatic mem_clear_test();
    id_ex      = random_instr();
    id_ex.wen  = 1'b1;
    id_ex.dwen = 1'b1;
    id_ex.dren = 1'b1;
    load_and_check("load_mem_op");
    dmem_access = 1'b1;
    dmem_busy   = 1'b0;
    id_ex       = random_instr();
    last.dwen   = 1'b0;
    last.dren   = 1'b0;
    hold_and_check("mem_clear");
    dmem_busy  = 1'b1;
    id_ex      = random_instr();
    id_ex.dren = 1'b1;
    load_and_check("mem_busy_load");
    dmem_access = 1'b0;
    dmem_busy   = 1'b0;
  endtask

  task automatic interrupt_test();
    intr  = 1'b1;
    pc_en = 1'b0;
    hold_and_check("intr_pulse");
    intr     = 1'b0;
    pc_en    = 1'b1;
    seen_exp = 1'b1;
    id_ex    = random_instr();
    load_and_check("intr_load");
    id_ex = random_instr();
    load_and_check("intr_still_set");
    // Load on the taken edge still carries the latched value
    intr_taken = 1'b1;
    id_ex      = random_instr();
    load_and_check("intr_taken");
    intr_taken = 1'b0;
    seen_exp   = 1'b0;
    id_ex      = random_instr();
    load_and_check("intr_cleared");
    intr  = 1'b1;
    pc_en = 1'b0;
    hold_and_check("intr_again");
    halt = 1'b1;
    last = ex_types_pkg::ex_mem_reset_c;
    hold_and_check("halt_with_intr");
    halt  = 1'b0;
    intr  = 1'b0;
    pc_en = 1'b1;
    id_ex = random_instr();
    load_and_check("after_halt");
  endtask

  initial begin
    seed_init    = $urandom(SEED);
    CLK          = 1'b0;
    nRST         = 1'b0;
    id_ex        = '0;
    fwd          = '0;
    pc_en        = 1'b0;
    ex_mem_flush = 1'b0;
    halt         = 1'b0;
    dmem_access  = 1'b0;
    dmem_busy    = 1'b0;
    intr         = 1'b0;
    intr_taken   = 1'b0;
    errors       = 0;
    checks       = 0;
    cycles       = 0;
    seen_exp     = 1'b0;
    last         = '0;

    apply_reset();
    alu_forwarding_test();
    branch_jump_test();
    mem_request_test();
    clear_hold_test();
    pc_en = 1'b1;
    mem_clear_test();
    interrupt_test();

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
ex_types_pkg.sv
ex_operand_select.sv
ex_alu.sv
ex_branch_resolve.sv
ex_mem_request.sv
ex_pipe_ctrl.sv
ex_mem_reg.sv
execute_stage.sv
tb_execute_stage.sv

// ==== Makefile ====
# Verilator build and run for the execute stage testbench

VERILATOR ?= verilator
TOP       ?= tb_execute_stage
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "SIMULATION FAILED" $(LOG); then \
	  echo "Result: failure, see $(LOG)"; exit 1; \
	else \
	  echo "Result: pass"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
